/* ptr_fields.svh */
`ifndef PTR_FIELDS_SVH
`define PTR_FIELDS_SVH

`define ptr_on_low 63
`define ptr_exp    62:58
`define ptr_hi     57:51
`define ptr_low    50:44
`define ptr_addr   43:0

`endif

/* agusec_pkg.sv */
package agusec_pkg;

  typedef logic [63:0] ptr_t;
  typedef logic [39:0] offset_t;
  typedef logic [4:0]  exp_t;
  typedef logic [6:0]  bound_t;
  typedef logic [7:0]  window_t;
  typedef logic [1:0]  code_t;
  typedef logic [7:0]  fault_cnt_t;

  typedef struct packed {
    logic    valid;
    ptr_t    ptr;
    offset_t a;
    offset_t b;
    logic    cin_secq; // still legal from the previous step
  } check_req_t;

  typedef struct packed {
    logic  valid;
    logic  legal;
    code_t pos_ack;
    code_t neg_ack;
    code_t pos_flip;
    code_t neg_flip;
    logic  nhi_less;
  } check_res_t;

  typedef struct packed {
    logic       req;
    logic       write;
    logic [1:0] addr;
    logic [7:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] rdata;
  } cfg_rsp_t;

endpackage

/* get_carry.sv */
`timescale 1ns/1ns

module get_carry #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic             cout
);

  localparam int LEVELS = $clog2(WIDTH + 1);

  // position 0 carries cin as a plain generate
  wire [WIDTH:0] g [0:LEVELS];
  wire [WIDTH:0] p [0:LEVELS];

  assign g[0] = {a & b, cin};
  assign p[0] = {a | b, 1'b0};

  for (genvar l = 0; l < LEVELS; l++) begin : level
    for (genvar i = 0; i <= WIDTH; i++) begin : node
      if (i >= (1 << l)) begin : merge
        assign g[l+1][i] = g[l][i] | (p[l][i] & g[l][i-(1<<l)]);
        assign p[l+1][i] = p[l][i] & p[l][i-(1<<l)];
      end else begin : pass
        assign g[l+1][i] = g[l][i];
        assign p[l+1][i] = p[l][i];
      end
    end
  end

  assign cout = g[LEVELS][WIDTH]; // group generate over all bits

endmodule

/* agusec_shift8.sv */
`timescale 1ns/1ns

module agusec_shift8 (
  input  agusec_pkg::exp_t    exp,
  input  logic [39:0]         addr,
  output agusec_pkg::window_t bits
);

  logic [39:0] s1;
  logic [39:0] s2;
  logic [39:0] s4;
  logic [39:0] s8;
  logic [39:0] s16;

  assign s1  = exp[0] ? (addr >> 1) : addr;
  assign s2  = exp[1] ? (s1 >> 2) : s1;
  assign s4  = exp[2] ? (s2 >> 4) : s2;
  assign s8  = exp[3] ? (s4 >> 8) : s4;
  assign s16 = exp[4] ? (s8 >> 16) : s8;

  assign bits = s16[7:0]; // window sits at addr bit 4+exp

endmodule

/* agusec_check.sv */
`timescale 1ns/1ns
`include "ptr_fields.svh"

module agusec_check_upper3 #(
  parameter bit AGU = 1'b1
) (
  input  agusec_pkg::ptr_t    ptr,
  input  agusec_pkg::offset_t a,
  input  agusec_pkg::offset_t b,
  output agusec_pkg::code_t   pos_ack,
  output agusec_pkg::code_t   neg_ack,
  output agusec_pkg::code_t   pos_flip,
  output agusec_pkg::code_t   neg_flip,
  output logic                nhi_less
);

  agusec_pkg::exp_t   exp;
  agusec_pkg::bound_t hi_f;
  agusec_pkg::bound_t low_f;
  logic [7:0]  msk;
  logic [40:0] or_ab;
  logic [40:0] xor_ab;
  logic [40:0] and_ab;
  logic on_hi;
  logic diff;
  logic hiff;
  logic max_exp;
  logic do_pos;
  logic do_pos2;
  logic do_neg;
  logic do_neg1;
  logic do_neg2;

  wire [3:0] lane_on;
  wire [3:0] pos0, pos2, neg0, neg1, neg2;
  wire [3:0] xpos0, xpos2, xneg0, xneg1, xneg2;

  assign exp     = ptr[`ptr_exp];
  assign hi_f    = ptr[`ptr_hi];
  assign low_f   = ptr[`ptr_low];
  assign or_ab   = {1'b0, a | b};
  assign xor_ab  = {1'b1, a ^ b};
  assign and_ab  = {1'b1, a & b};
  assign on_hi   = ~ptr[`ptr_on_low];
  assign diff    = ~nhi_less;              // bounds wrap
  assign hiff    = (AGU == 1'b0) && (&hi_f); // store port only
  assign max_exp = &exp;

  // within-byte mask, top bit saturates at 6
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      msk[i] = (int'(exp[2:0]) <= ((i < 7) ? i : 6));
    end
  end

  get_carry #(.WIDTH(7)) hi_low_cmp (
    .a    (hi_f),
    .b    (~low_f),
    .cin  (1'b1),
    .cout (nhi_less)
  );

  for (genvar p = 0; p < 4; p++) begin : lane
    assign lane_on[p] = (exp[4:3] < p); // whole lane above the window

    assign pos0[p] = ~lane_on[p] || ~|or_ab[p*8+8+:8];
    assign pos2[p] = ~lane_on[p] || ~|or_ab[p*8+9+:8];
    assign neg0[p] = ~lane_on[p] || &xor_ab[p*8+8+:8];
    assign neg1[p] = ~lane_on[p] || &and_ab[p*8+8+:8];
    assign neg2[p] = ~lane_on[p] || &xor_ab[p*8+9+:8];

    // partial lane holding the window edge
    assign xpos0[p] = (p != exp[4:3]) || ~|(or_ab[p*8+8+:8] & msk);
    assign xpos2[p] = (p != exp[4:3]) || ~|(or_ab[p*8+9+:8] & msk);
    assign xneg0[p] = (p != exp[4:3]) || &(xor_ab[p*8+8+:8] | msk);
    assign xneg1[p] = (p != exp[4:3]) || &(and_ab[p*8+8+:8] | msk);
    assign xneg2[p] = (p != exp[4:3]) || &(xor_ab[p*8+9+:8] | msk);
  end

  assign do_pos  = (&pos0) && (&xpos0);
  assign do_pos2 = (&pos2) && (&xpos2);
  assign do_neg  = (&neg0) && (&xneg0);
  assign do_neg1 = (&neg1) && (&xneg1);
  assign do_neg2 = (&neg2) && (&xneg2);

  assign pos_ack[1] = (do_pos && ~on_hi && (diff || hiff)) || max_exp; // carry in 1
  assign pos_ack[0] = do_pos || (do_pos2 && ~on_hi && (diff || hiff)) || max_exp;
  assign neg_ack[1] = do_neg || ((do_neg2 || do_neg1) && ~on_hi && diff);
  assign neg_ack[0] = do_neg && ~on_hi && diff;

  assign pos_flip[1] = (do_pos && ~on_hi && diff) || (do_pos2 && ~on_hi && hiff);
  assign pos_flip[0] = (do_pos2 && ~do_pos && ~on_hi && diff) ||
                       (do_pos && ~on_hi && hiff);
  assign neg_flip[1] = (do_neg2 || do_neg1) && ~do_neg && ~on_hi && diff;
  assign neg_flip[0] = do_neg && ~on_hi && diff;

  // a half flip is only legal when the AGU also gets an ack
  always_comb begin
    if (!$isunknown({ptr, a, b})) begin
      flip_needs_ack: assert final (!(|pos_flip) || (|pos_ack))
        else $error("pos_flip %b without pos_ack", pos_flip);
    end
  end

endmodule

module agusec_range (
  input  agusec_pkg::ptr_t ptr,
  input  logic             cin_secq,
  input  logic             diff,
  output logic             cout_secq
);

  agusec_pkg::window_t low_ext;
  agusec_pkg::window_t high_ext;
  agusec_pkg::window_t bits;
  logic [43:0] addr;
  logic hi_pass;
  logic lo_pass;
  logic low_ok;
  logic high_ok;

  assign addr     = ptr[`ptr_addr];
  assign low_ext  = {ptr[`ptr_low], 1'b0};
  assign high_ext = {ptr[`ptr_hi], 1'b1};
  assign hi_pass  = diff && ptr[`ptr_on_low];  // wrapped, upper test waived
  assign lo_pass  = diff && ~ptr[`ptr_on_low]; // wrapped, lower test waived

  agusec_shift8 window_sh (
    .exp  (ptr[`ptr_exp]),
    .addr (addr[43:4]),
    .bits (bits)
  );

  get_carry #(.WIDTH(8)) low_cmp (
    .a    (~low_ext),
    .b    (bits),
    .cin  (1'b1),
    .cout (low_ok)   // bits >= low
  );

  get_carry #(.WIDTH(8)) high_cmp (
    .a    (high_ext),
    .b    (~bits),
    .cin  (1'b1),
    .cout (high_ok)  // high >= bits
  );

  assign cout_secq = cin_secq && (low_ok || lo_pass) && (high_ok || hi_pass);

endmodule

/* agusec_unit.sv */
`timescale 1ns/1ns

module agusec_unit #(
  parameter bit AGU = 1'b1
) (
  input  logic                   clk,
  input  logic                   reset,
  input  agusec_pkg::check_req_t req_in,
  input  logic                   enable,
  output agusec_pkg::check_res_t res_out,
  output logic                   fault_pulse
);

  agusec_pkg::check_req_t req_q;
  agusec_pkg::check_res_t res_q;
  agusec_pkg::code_t pos_ack;
  agusec_pkg::code_t neg_ack;
  agusec_pkg::code_t pos_flip;
  agusec_pkg::code_t neg_flip;
  logic nhi_less;
  logic legal;

  always_ff @(posedge clk) begin
    req_q <= req_in;
    if (reset) begin
      req_q.valid <= 1'b0;
    end
  end

  agusec_check_upper3 #(.AGU(AGU)) upper_chk (
    .ptr      (req_q.ptr),
    .a        (req_q.a),
    .b        (req_q.b),
    .pos_ack  (pos_ack),
    .neg_ack  (neg_ack),
    .pos_flip (pos_flip),
    .neg_flip (neg_flip),
    .nhi_less (nhi_less)
  );

  agusec_range range_chk (
    .ptr       (req_q.ptr),
    .cin_secq  (req_q.cin_secq),
    .diff      (~nhi_less),
    .cout_secq (legal)
  );

  always_ff @(posedge clk) begin
    res_q.legal    <= legal || ~enable; // checking off, pass all
    res_q.pos_ack  <= pos_ack;
    res_q.neg_ack  <= neg_ack;
    res_q.pos_flip <= pos_flip;
    res_q.neg_flip <= neg_flip;
    res_q.nhi_less <= nhi_less;
    if (reset) begin
      res_q.valid <= 1'b0;
    end else begin
      res_q.valid <= req_q.valid;
    end
  end

  assign res_out     = res_q;
  assign fault_pulse = res_q.valid && ~res_q.legal;

  fixed_latency: assert property (@(posedge clk) disable iff (reset)
    req_in.valid |-> ##2 res_out.valid)
    else $error("check result missing two cycles after request");

endmodule

/* agusec_cfg.sv */
`timescale 1ns/1ns

module agusec_cfg (
  input  logic                 clk,
  input  logic                 reset,
  input  agusec_pkg::cfg_req_t cfg_in,
  output agusec_pkg::cfg_rsp_t cfg_out,
  input  logic                 fault_pulse,
  output logic                 enable
);

  typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} state_t;

  state_t state;
  agusec_pkg::fault_cnt_t fault_cnt;
  logic       fault_flag;
  logic [7:0] rdata_q;
  logic       access;

  assign access = (state == IDLE) && cfg_in.req;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:     state <= cfg_in.req ? ACK : IDLE;
        ACK:      state <= cfg_in.req ? WAIT_LOW : IDLE;
        WAIT_LOW: state <= cfg_in.req ? WAIT_LOW : IDLE;
        default:  state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enable     <= 1'b1;
      fault_cnt  <= '0;
      fault_flag <= 1'b0;
    end else begin
      if (fault_pulse) begin
        fault_flag <= 1'b1;
        if (fault_cnt != '1) begin
          fault_cnt <= fault_cnt + 1'b1; // saturate at 255
        end
      end
      if (access && cfg_in.write) begin // write beats a same-cycle fault
        case (cfg_in.addr)
          2'd0:    enable <= cfg_in.wdata[0];
          2'd1:    fault_cnt <= '0;
          2'd2:    fault_flag <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (cfg_in.addr)
        2'd0:    rdata_q <= {7'b0, enable};
        2'd1:    rdata_q <= fault_cnt;
        2'd2:    rdata_q <= {7'b0, fault_flag};
        default: rdata_q <= '0;
      endcase
    end
  end

  assign cfg_out.ack   = (state != IDLE);
  assign cfg_out.rdata = rdata_q;

  ack_after_req: assert property (@(posedge clk) disable iff (reset)
    $rose(cfg_out.ack) |-> $past(cfg_in.req))
    else $error("cfg ack raised without a request");

endmodule

/* agusec_top.sv */
`timescale 1ns/1ns

module agusec_top #(
  parameter bit AGU = 1'b1
) (
  input  logic                   clk,
  input  logic                   reset,
  input  agusec_pkg::check_req_t req_in,
  output agusec_pkg::check_res_t res_out,
  input  agusec_pkg::cfg_req_t   cfg_in,
  output agusec_pkg::cfg_rsp_t   cfg_out
);

  logic enable;
  logic fault_pulse;

  agusec_unit #(.AGU(AGU)) agusec_unit_inst (
    .clk         (clk),
    .reset       (reset),
    .req_in      (req_in),
    .enable      (enable),
    .res_out     (res_out),
    .fault_pulse (fault_pulse)
  );

  agusec_cfg agusec_cfg_inst (
    .clk         (clk),
    .reset       (reset),
    .cfg_in      (cfg_in),
    .cfg_out     (cfg_out),
    .fault_pulse (fault_pulse),
    .enable      (enable)
  );

endmodule

/* tb_agusec_checker.sv */
`timescale 1ns/1ns

module tb_agusec_checker (
  input logic                   clk,
  input logic                   reset,
  input agusec_pkg::check_res_t res_out,
  input agusec_pkg::cfg_req_t   cfg_in,
  input agusec_pkg::cfg_rsp_t   cfg_out
);

  string                  res_name_q [$];
  agusec_pkg::check_res_t res_exp_q  [$];
  logic                   codes_q    [$];
  int                     due_q      [$];
  string                  rd_name_q  [$];
  logic [7:0]             rd_exp_q   [$];
  int   cycle_cnt    = 0;
  int   error_count  = 0;
  int   result_count = 0;
  int   read_count   = 0;
  logic ack_prev     = 1'b0;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic expect_result(input string name, input agusec_pkg::check_res_t exp_res,
                               input logic codes);
    res_name_q.push_back(name);
    res_exp_q.push_back(exp_res);
    codes_q.push_back(codes);
    due_q.push_back(cycle_cnt + 3); // seen at the negedge two cycles after entry
  endtask

  task automatic expect_read(input string name, input logic [7:0] value);
    rd_name_q.push_back(name);
    rd_exp_q.push_back(value);
  endtask

  function automatic int pending();
    return res_name_q.size() + rd_name_q.size();
  endfunction

  task automatic compare(input string name, input string field, input logic [7:0] exp_v,
                         input logic [7:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %s %s expected %0h actual %0h", name, field, exp_v, act_v);
      error_count++;
    end
  endtask

  always @(negedge clk) begin : watch
    string name;
    agusec_pkg::check_res_t exp_res;
    logic codes;
    int due;
    logic [7:0] value;
    if (!reset && res_out.valid) begin
      if (res_name_q.size() == 0) begin
        $display("check result arrived with no request in flight");
        error_count++;
      end else begin
        name    = res_name_q.pop_front();
        exp_res = res_exp_q.pop_front();
        codes   = codes_q.pop_front();
        due     = due_q.pop_front();
        result_count++;
        if (cycle_cnt != due) begin
          $display("%s result came at cycle %0d instead of %0d", name, cycle_cnt, due);
          error_count++;
        end
        compare(name, "legal", 8'(exp_res.legal), 8'(res_out.legal));
        compare(name, "nhi_less", 8'(exp_res.nhi_less), 8'(res_out.nhi_less));
        if (codes) begin
          compare(name, "pos_ack", 8'(exp_res.pos_ack), 8'(res_out.pos_ack));
          compare(name, "neg_ack", 8'(exp_res.neg_ack), 8'(res_out.neg_ack));
          compare(name, "pos_flip", 8'(exp_res.pos_flip), 8'(res_out.pos_flip));
          compare(name, "neg_flip", 8'(exp_res.neg_flip), 8'(res_out.neg_flip));
        end
      end
    end
    if (!reset && cfg_out.ack && !ack_prev && !cfg_in.write) begin // read data on ack rise
      if (rd_name_q.size() == 0) begin
        $display("config read finished with no expected value queued");
        error_count++;
      end else begin
        name  = rd_name_q.pop_front();
        value = rd_exp_q.pop_front();
        read_count++;
        compare(name, "rdata", value, cfg_out.rdata);
      end
    end
    ack_prev = cfg_out.ack;
  end

endmodule

/* tb_agusec.sv */
`timescale 1ns/1ns

module tb_agusec;

  localparam int N_CASES = 12;
  localparam int N_CFG   = 7; // config accesses in the run
  localparam int LIMIT   = 2 + 2 * (N_CASES + 6) + N_CFG * 8 + 40;

  logic clk;
  logic reset;
  agusec_pkg::check_req_t req_in;
  agusec_pkg::check_res_t res_out;
  agusec_pkg::cfg_req_t   cfg_in;
  agusec_pkg::cfg_rsp_t   cfg_out;

  string                  names      [N_CASES];
  agusec_pkg::ptr_t       ptrs       [N_CASES];
  agusec_pkg::offset_t    offs_a     [N_CASES];
  agusec_pkg::offset_t    offs_b     [N_CASES];
  agusec_pkg::check_res_t expect_tbl [N_CASES];
  logic                   cins       [N_CASES];
  logic                   chk_codes  [N_CASES];
  int n_cases   = 0;
  int n_illegal = 0;
  int cycles    = 0;

  agusec_top #(.AGU(1'b1)) agusec_top_inst (
    .clk     (clk),
    .reset   (reset),
    .req_in  (req_in),
    .res_out (res_out),
    .cfg_in  (cfg_in),
    .cfg_out (cfg_out)
  );

  tb_agusec_checker checker_inst (
    .clk     (clk),
    .reset   (reset),
    .res_out (res_out),
    .cfg_in  (cfg_in),
    .cfg_out (cfg_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic agusec_pkg::ptr_t make_ptr(input logic on_low, input int e, input int hi,
                                                input int low, input int win);
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    logic [43:0] addr;
    r_hi = $urandom;
    r_lo = $urandom;
    addr = {r_hi[11:0], r_lo};
    addr[4 + e +: 8] = 8'(win); // random bits around the window
    return {on_low, 5'(e), 7'(hi), 7'(low), addr};
  endfunction

  task automatic add_case(input string name, input int on_low, input int e, input int hi,
                          input int low, input int win, input agusec_pkg::offset_t a,
                          input agusec_pkg::offset_t b, input int cin, input int legal,
                          input int chk, input logic [7:0] codes);
    names[n_cases]      = name;
    ptrs[n_cases]       = make_ptr(on_low != 0, e, hi, low, win);
    offs_a[n_cases]     = a;
    offs_b[n_cases]     = b;
    cins[n_cases]       = (cin != 0);
    chk_codes[n_cases]  = (chk != 0);
    expect_tbl[n_cases] = '{valid: 1'b1, legal: legal != 0, pos_ack: codes[7:6],
                            neg_ack: codes[5:4], pos_flip: codes[3:2], neg_flip: codes[1:0],
                            nhi_less: hi >= low}; // low when bounds wrap
    if (legal == 0) begin
      n_illegal++;
    end
    n_cases++;
  endtask

  task automatic run_table(input string tag, input logic enabled);
    agusec_pkg::check_res_t exp_res;
    for (int i = 0; i < n_cases; i++) begin
      @(posedge clk);
      req_in <= '{valid: 1'b1, ptr: ptrs[i], a: offs_a[i], b: offs_b[i], cin_secq: cins[i]};
      exp_res = expect_tbl[i];
      exp_res.legal = exp_res.legal || !enabled; // checking off, all legal
      checker_inst.expect_result({tag, names[i]}, exp_res, chk_codes[i]);
    end
    @(posedge clk);
    req_in <= '0;
    while (checker_inst.pending() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk); // let the fault counter settle
  endtask

  task automatic cfg_access(input logic write, input logic [1:0] addr, input logic [7:0] wdata);
    @(posedge clk);
    cfg_in <= '{req: 1'b1, write: write, addr: addr, wdata: wdata};
    do @(posedge clk); while (!cfg_out.ack);
    cfg_in.req <= 1'b0;
    do @(posedge clk); while (cfg_out.ack);
  endtask

  task automatic cfg_read(input string name, input logic [1:0] addr, input logic [7:0] value);
    checker_inst.expect_read(name, value);
    cfg_access(1'b0, addr, 8'h00);
  endtask

  initial begin
    req_in = '0;
    cfg_in = '0;
    reset  = 1'b1;
    void'($urandom(10));
    //       name            on_low exp hi  low win  a   b  cin lgl chk  codes
    add_case("in_mid",       0, 4,  40,  10, 50,  '0, '0, 1, 1, 1, 8'b01_00_00_00);
    add_case("in_low_edge",  0, 0,  40,  10, 20,  '0, '0, 1, 1, 1, 8'b01_00_00_00);
    add_case("in_high_edge", 0, 12, 40,  10, 81,  '0, '0, 1, 1, 1, 8'b01_00_00_00);
    add_case("below_low",    0, 7,  40,  10, 19,  '0, '0, 1, 0, 1, 8'b01_00_00_00);
    add_case("above_high",   0, 20, 40,  10, 82,  '0, '0, 1, 0, 1, 8'b01_00_00_00);
    add_case("max_exp",      0, 31, 100, 2,  150, '0, '0, 1, 1, 1, 8'b11_00_00_00);
    add_case("wrap_lo_pass", 1, 3,  10,  50, 200, '0, '0, 1, 1, 0, 8'h00);
    add_case("wrap_lo_fail", 1, 3,  10,  50, 99,  '0, '0, 1, 0, 0, 8'h00);
    add_case("wrap_hi_pass", 0, 9,  10,  50, 5,   '0, '0, 1, 1, 0, 8'h00);
    add_case("wrap_hi_fail", 0, 9,  10,  50, 22,  '0, '0, 1, 0, 0, 8'h00);
    add_case("cin_low",      0, 4,  40,  10, 50,  '0, '0, 0, 0, 1, 8'b01_00_00_00);
    add_case("neg_wrap",     1, 4,  10,  50, 200, '1, '0, 1, 1, 1, 8'b00_11_00_01);
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    run_table("en_", 1'b1);
    cfg_read("fault_cnt", 2'd1, 8'(n_illegal));
    cfg_read("fault_flag", 2'd2, 8'd1);
    cfg_access(1'b1, 2'd1, 8'h00); // clear counter
    cfg_read("fault_cnt_clr", 2'd1, 8'd0);
    cfg_access(1'b1, 2'd0, 8'h00); // enable off
    cfg_read("control", 2'd0, 8'd0);
    run_table("dis_", 1'b0);
    cfg_read("fault_cnt_dis", 2'd1, 8'd0);
    $display("results %0d, reads %0d, errors %0d", checker_inst.result_count,
             checker_inst.read_count, checker_inst.error_count);
    if (checker_inst.error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, errors %0d", LIMIT, checker_inst.error_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* all.f */
+incdir+.
agusec_pkg.sv
get_carry.sv
agusec_shift8.sv
agusec_check.sv
agusec_unit.sv
agusec_cfg.sv
agusec_top.sv
tb_agusec_checker.sv
tb_agusec.sv

/* Bender.yml */
package:
  name: agusec

sources:
  - include_dirs:
      - .
    files:
      - agusec_pkg.sv
      - get_carry.sv
      - agusec_shift8.sv
      - agusec_check.sv
      - agusec_unit.sv
      - agusec_cfg.sv
      - agusec_top.sv
  - target: simulation
    files:
      - tb_agusec_checker.sv
      - tb_agusec.sv
